// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = proc_tb
FILELIST = filelist.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/proc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module proc_tb;

	localparam int n_rows = 14;
	localparam int cycle_ns = 100;
	localparam int kind_alu_r = 0;
	localparam int kind_alu_i = 1;
	localparam int kind_ldst = 2;
	localparam int kind_branch = 3;
	localparam int kind_jump = 4;

	logic clk;
	logic arst_n;
	logic [15:0] imem_addr;
	logic [15:0] imem_data;
	logic dmem_en;
	logic dmem_wr;
	logic [15:0] dmem_addr;
	logic [15:0] dmem_wdata;
	logic [15:0] dmem_rdata;
	logic halted;

	logic [15:0] imem [256];
	logic [15:0] dmem [256];
	logic [15:0] log_addr [$];
	logic [15:0] log_data [$];
	int read_cnt;
	logic [15:0] read_addr;
	int prog_len;
	int value_errs;
	int other_errs;
	int seed;
	logic [31:0] rnd;

	// Stimulus table and expected stores
	int row_kind [n_rows];
	isa_pkg::opcode_t row_op [n_rows];
	isa_pkg::funct_t row_fn [n_rows];
	logic [15:0] row_a [n_rows];
	logic [15:0] row_b [n_rows];
	int exp_cnt [n_rows];
	int exp_reads [n_rows];
	logic [15:0] exp_addr [n_rows][3];
	logic [15:0] exp_data [n_rows][3];

	proc proc_i (.*);

	always #50 clk = ~clk;

	assign imem_data = imem[imem_addr[8:1]];
	assign dmem_rdata = dmem[dmem_addr[8:1]];

	// Store and load log sampled on the falling edge where strobes are stable
	always @(negedge clk) begin
		if (dmem_en && dmem_wr) begin
			assert (!halted) else begin
				other_errs++;
				$display("Store to address %h happened after halted rose, at %0t", dmem_addr, $time);
			end
			log_addr.push_back(dmem_addr);
			log_data.push_back(dmem_wdata);
			dmem[dmem_addr[8:1]] = dmem_wdata;
		end
		if (dmem_en && !dmem_wr) begin
			read_cnt++;
			read_addr = dmem_addr;
		end
	end

	function automatic logic [15:0] enc_r(input isa_pkg::funct_t fn, input logic [2:0] rs,
		input logic [2:0] rt, input logic [2:0] rd);
		return {isa_pkg::op_rtype, rs, rt, rd, fn};
	endfunction

	function automatic logic [15:0] enc_i(input isa_pkg::opcode_t op, input logic [2:0] rs,
		input logic [2:0] rt, input logic [4:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [15:0] enc_i8(input isa_pkg::opcode_t op, input logic [2:0] rs,
		input logic [7:0] imm);
		return {op, rs, imm};
	endfunction

	// Result with x as Rs and y as Rt or the immediate
	function automatic logic [15:0] model_alu(input int kind, input isa_pkg::opcode_t op,
		input isa_pkg::funct_t fn, input logic [15:0] x, input logic [15:0] y);
		logic [15:0] sx;
		logic [15:0] zx;
		sx = {{11{y[4]}}, y[4:0]};
		zx = {11'd0, y[4:0]};
		if (kind == kind_alu_r) begin
			case (fn)
				isa_pkg::fn_sub:  return y - x;
				isa_pkg::fn_xor:  return x ^ y;
				isa_pkg::fn_andn: return x & ~y;
				default:          return x + y;
			endcase
		end
		case (op)
			isa_pkg::op_subi:  return sx - x;
			isa_pkg::op_xori:  return x ^ zx;
			isa_pkg::op_andni: return x & ~zx;
			default:           return x + sx;
		endcase
	endfunction

	task automatic set_row(input int r, input int kind, input isa_pkg::opcode_t op,
		input isa_pkg::funct_t fn);
		row_kind[r] = kind;
		row_op[r] = op;
		row_fn[r] = fn;
	endtask

	task automatic add_expect(input int r, input logic [15:0] addr, input logic [15:0] data);
		exp_addr[r][exp_cnt[r]] = addr;
		exp_data[r][exp_cnt[r]] = data;
		exp_cnt[r]++;
	endtask

	task automatic build_table();
		logic [15:0] first;
		logic [15:0] second;
		logic taken;
		seed = 91017;
		for (int i = 0; i < n_rows; i++) begin
			rnd = $random(seed);
			row_a[i] = rnd[15:0];
			rnd = $random(seed);
			row_b[i] = rnd[15:0];
		end
		set_row(0, kind_alu_r, isa_pkg::op_rtype, isa_pkg::fn_add);
		set_row(1, kind_alu_r, isa_pkg::op_rtype, isa_pkg::fn_sub);
		set_row(2, kind_alu_r, isa_pkg::op_rtype, isa_pkg::fn_xor);
		set_row(3, kind_alu_r, isa_pkg::op_rtype, isa_pkg::fn_andn);
		set_row(4, kind_alu_i, isa_pkg::op_addi, isa_pkg::fn_add);
		set_row(5, kind_alu_i, isa_pkg::op_subi, isa_pkg::fn_add);
		set_row(6, kind_alu_i, isa_pkg::op_xori, isa_pkg::fn_add);
		set_row(7, kind_alu_i, isa_pkg::op_andni, isa_pkg::fn_add);
		set_row(8, kind_ldst, isa_pkg::op_ld, isa_pkg::fn_add);
		set_row(9, kind_branch, isa_pkg::op_beqz, isa_pkg::fn_add);
		set_row(10, kind_branch, isa_pkg::op_beqz, isa_pkg::fn_add);
		set_row(11, kind_branch, isa_pkg::op_bnez, isa_pkg::fn_add);
		set_row(12, kind_branch, isa_pkg::op_bnez, isa_pkg::fn_add);
		set_row(13, kind_jump, isa_pkg::op_j, isa_pkg::fn_add);
		// Zero and nonzero branch operands
		row_a[9] = 16'h0000;
		row_a[10] = row_a[10] | 16'h0100;
		row_a[11] = row_a[11] | 16'h0100;
		row_a[12] = 16'h0000;
		for (int r = 0; r < n_rows; r++) begin
			exp_cnt[r] = 0;
			exp_reads[r] = 0;
			case (row_kind[r])
				kind_alu_r, kind_alu_i: begin
					first = model_alu(row_kind[r], row_op[r], row_fn[r], row_a[r], row_b[r]);
					second = model_alu(row_kind[r], row_op[r], row_fn[r], first, row_b[r]);
					add_expect(r, 16'h0040, second);
					add_expect(r, 16'h0042, first);
				end
				kind_ldst: begin
					exp_reads[r] = 1;
					add_expect(r, 16'h0044, row_a[r]);
					add_expect(r, 16'h0046, row_a[r] + 16'd3);
					add_expect(r, 16'h0048, row_a[r]);
				end
				kind_branch: begin
					taken = (row_op[r] == isa_pkg::op_beqz) == (row_a[r] == 16'h0000);
					if (!taken) begin
						add_expect(r, 16'h0040, 16'h005a);
						add_expect(r, 16'h0042, 16'h005a);
					end
					add_expect(r, 16'h0044, 16'h0033);
				end
				default: add_expect(r, 16'h0044, 16'h0033);
			endcase
		end
	endtask

	task automatic put_word(input logic [15:0] w);
		imem[prog_len] = w;
		prog_len++;
	endtask

	// lbi then slbi gives any 16-bit value
	task automatic load_const(input logic [2:0] rd, input logic [15:0] value);
		put_word(enc_i8(isa_pkg::op_lbi, rd, value[15:8]));
		put_word(enc_i8(isa_pkg::op_slbi, rd, value[7:0]));
	endtask

	task automatic load_program(input int r);
		logic [4:0] imm;
		imm = row_b[r][4:0];
		// Unused words decode as halt
		for (int i = 0; i < 256; i++) begin
			imem[i] = 16'h0000;
		end
		prog_len = 0;
		case (row_kind[r])
			kind_alu_r, kind_alu_i: begin
				load_const(3'd1, row_a[r]);
				load_const(3'd2, row_b[r]);
				put_word(enc_i8(isa_pkg::op_lbi, 3'd7, 8'h40));
				if (row_kind[r] == kind_alu_r) begin
					put_word(enc_r(row_fn[r], 3'd1, 3'd2, 3'd3));
					put_word(enc_r(row_fn[r], 3'd3, 3'd2, 3'd4));
				end else begin
					put_word(enc_i(row_op[r], 3'd1, 3'd3, imm));
					put_word(enc_i(row_op[r], 3'd3, 3'd4, imm));
				end
				put_word(enc_i(isa_pkg::op_st, 3'd7, 3'd4, 5'd0));
				put_word(enc_i(isa_pkg::op_st, 3'd7, 3'd3, 5'd2));
			end
			kind_ldst: begin
				put_word(enc_i8(isa_pkg::op_lbi, 3'd7, 8'h40));
				load_const(3'd1, row_a[r]);
				put_word(enc_i(isa_pkg::op_st, 3'd7, 3'd1, 5'd4));
				put_word(enc_i(isa_pkg::op_ld, 3'd7, 3'd5, 5'd4));
				// Load-use on the very next word
				put_word(enc_i(isa_pkg::op_addi, 3'd5, 3'd6, 5'd3));
				put_word(enc_i(isa_pkg::op_st, 3'd7, 3'd6, 5'd6));
				put_word(enc_i(isa_pkg::op_st, 3'd7, 3'd5, 5'd8));
			end
			default: begin
				put_word(enc_i8(isa_pkg::op_lbi, 3'd7, 8'h40));
				put_word(enc_i8(isa_pkg::op_lbi, 3'd2, 8'h5a));
				put_word(enc_i8(isa_pkg::op_lbi, 3'd3, 8'h33));
				if (row_kind[r] == kind_branch) begin
					load_const(3'd1, row_a[r]);
					put_word(enc_i8(row_op[r], 3'd1, 8'd4));
				end else begin
					put_word({isa_pkg::op_j, 11'd4});
				end
				// Two marker slots before the target
				put_word(enc_i(isa_pkg::op_st, 3'd7, 3'd2, 5'd0));
				put_word(enc_i(isa_pkg::op_st, 3'd7, 3'd2, 5'd2));
				put_word(enc_i(isa_pkg::op_st, 3'd7, 3'd3, 5'd4));
			end
		endcase
		put_word({isa_pkg::op_halt, 11'd0});
		// Stores past the halt that must never execute
		for (int i = 0; i < 3; i++) begin
			put_word(enc_i(isa_pkg::op_st, 3'd7, 3'd7, 5'd14));
		end
	endtask

	task automatic check_accesses(input int r);
		assert (log_addr.size() == exp_cnt[r]) else begin
			value_errs++;
			$display("FAIL %0t: row %0d made %0d stores, expected %0d",
				$time, r, log_addr.size(), exp_cnt[r]);
		end
		for (int i = 0; i < exp_cnt[r] && i < log_addr.size(); i++) begin
			assert (log_addr[i] == exp_addr[r][i] && log_data[i] == exp_data[r][i]) else begin
				value_errs++;
				$display("FAIL %0t: row %0d store %0d wrote %h to %h, expected %h to %h",
					$time, r, i, log_data[i], log_addr[i], exp_data[r][i], exp_addr[r][i]);
			end
		end
		assert (read_cnt == exp_reads[r]) else begin
			value_errs++;
			$display("FAIL %0t: row %0d made %0d loads, expected %0d",
				$time, r, read_cnt, exp_reads[r]);
		end
		if (exp_reads[r] > 0) begin
			assert (read_addr == 16'h0044) else begin
				value_errs++;
				$display("FAIL %0t: row %0d loaded from %h, expected 0044", $time, r, read_addr);
			end
		end
	endtask

	task automatic run_row(input int r);
		int cycles;
		logic [7:0] idx;
		@(negedge clk);
		arst_n = 1'b0;
		log_addr.delete();
		log_data.delete();
		read_cnt = 0;
		for (int i = 0; i < 256; i++) begin
			idx = i[7:0];
			dmem[i] = {idx, ~idx};
		end
		load_program(r);
		repeat (2) @(negedge clk);
		assert (dmem_en == 1'b0 && halted == 1'b0) else begin
			value_errs++;
			$display("FAIL %0t: dmem_en %b halted %b during reset", $time, dmem_en, halted);
		end
		arst_n = 1'b1;
		cycles = 0;
		while (!halted && cycles < 150) begin
			@(negedge clk);
			cycles++;
		end
		assert (halted) else begin
			other_errs++;
			$display("Row %0d did not reach halt within 150 cycles", r);
		end
		// Any store from here on is an error
		repeat (4) @(negedge clk);
		check_accesses(r);
	endtask

	initial begin
		#(n_rows * 200 * cycle_ns);
		$display("Watchdog expired before all rows finished");
		$display("Simulation failed");
		$finish;
	end

	initial begin
		clk = 1'b0;
		arst_n = 1'b0;
		value_errs = 0;
		other_errs = 0;
		read_cnt = 0;
		build_table();
		for (int r = 0; r < n_rows; r++) begin
			run_row(r);
		end
		$display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/mem_wb_stage.sv
logic/hazard_unit.sv
logic/proc.sv
dv/proc_tb.sv

// File: logic/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
	input  wire                           clk,
	input  wire                           arst_n,
	input  wire  [isa_pkg::word_w-1:0]    id_instr,
	input  wire  [isa_pkg::word_w-1:0]    id_pc2,
	input  wire                           stall,
	input  wire                           flush,
	input  wire  [isa_pkg::reg_w-1:0]     wb_sel,
	input  wire  [isa_pkg::word_w-1:0]    wb_data,
	input  wire                           wb_en,
	output logic                          halt_seen,
	output logic [isa_pkg::reg_w-1:0]     rs_sel,
	output logic [isa_pkg::reg_w-1:0]     rt_sel,
	output logic [isa_pkg::reg_w-1:0]     ex_rs_sel,
	output logic [isa_pkg::reg_w-1:0]     ex_rt_sel,
	output logic [isa_pkg::word_w-1:0]    ex_rs_val,
	output logic [isa_pkg::word_w-1:0]    ex_rt_val,
	output logic [isa_pkg::disp11_w-1:0]  ex_imm,
	output pipe_pkg::b_src_t              ex_b_src,
	output pipe_pkg::alu_op_t             ex_alu_op,
	output logic [isa_pkg::reg_w-1:0]     ex_wr_sel,
	output logic                          ex_reg_wr,
	output logic                          ex_mem_rd,
	output logic                          ex_mem_wr,
	output logic                          ex_branch,
	output logic                          ex_jump,
	output logic                          ex_halt,
	output logic [isa_pkg::word_w-1:0]    ex_pc2,
	output isa_pkg::opcode_t              ex_opcode
);

	isa_pkg::opcode_t opcode;
	isa_pkg::funct_t funct;
	logic [isa_pkg::reg_w-1:0] rd_sel;
	logic [isa_pkg::word_w-1:0] regs [isa_pkg::reg_n];
	logic [isa_pkg::word_w-1:0] rs_val;
	logic [isa_pkg::word_w-1:0] rt_val;
	logic halt_q;
	logic kill;

	// Decoded control
	pipe_pkg::alu_op_t alu_op;
	pipe_pkg::b_src_t b_src;
	logic [isa_pkg::reg_w-1:0] wr_sel;
	logic reg_wr;
	logic mem_rd;
	logic mem_wr;
	logic branch;
	logic jump;
	logic halt;

	assign opcode = isa_pkg::opcode_t'(id_instr[isa_pkg::op_lsb +: isa_pkg::op_w]);
	assign funct = isa_pkg::funct_t'(id_instr[isa_pkg::funct_lsb +: isa_pkg::funct_w]);
	assign rs_sel = id_instr[isa_pkg::rs_lsb +: isa_pkg::reg_w];
	assign rt_sel = id_instr[isa_pkg::rt_lsb +: isa_pkg::reg_w];
	assign rd_sel = id_instr[isa_pkg::rd_lsb +: isa_pkg::reg_w];

	always_comb begin
		alu_op = pipe_pkg::alu_add;
		b_src = pipe_pkg::b_imm_sext5;
		wr_sel = rt_sel;
		reg_wr = 1'b0;
		mem_rd = 1'b0;
		mem_wr = 1'b0;
		branch = 1'b0;
		jump = 1'b0;
		halt = 1'b0;
		case (opcode)
			isa_pkg::op_rtype: begin
				reg_wr = 1'b1;
				wr_sel = rd_sel;
				b_src = pipe_pkg::b_rt;
				case (funct)
					isa_pkg::fn_sub:  alu_op = pipe_pkg::alu_sub;
					isa_pkg::fn_xor:  alu_op = pipe_pkg::alu_xor;
					isa_pkg::fn_andn: alu_op = pipe_pkg::alu_andn;
					default:          alu_op = pipe_pkg::alu_add;
				endcase
			end
			isa_pkg::op_addi: reg_wr = 1'b1;
			isa_pkg::op_subi: begin
				reg_wr = 1'b1;
				alu_op = pipe_pkg::alu_sub;
			end
			// Logical immediates are zero extended
			isa_pkg::op_xori: begin
				reg_wr = 1'b1;
				alu_op = pipe_pkg::alu_xor;
				b_src = pipe_pkg::b_imm_zext5;
			end
			isa_pkg::op_andni: begin
				reg_wr = 1'b1;
				alu_op = pipe_pkg::alu_andn;
				b_src = pipe_pkg::b_imm_zext5;
			end
			isa_pkg::op_ld: begin
				reg_wr = 1'b1;
				mem_rd = 1'b1;
			end
			isa_pkg::op_st: mem_wr = 1'b1;
			// Rs field is the destination here
			isa_pkg::op_lbi: begin
				reg_wr = 1'b1;
				wr_sel = rs_sel;
				alu_op = pipe_pkg::alu_pass_b;
				b_src = pipe_pkg::b_imm_sext8;
			end
			isa_pkg::op_slbi: begin
				reg_wr = 1'b1;
				wr_sel = rs_sel;
				alu_op = pipe_pkg::alu_shift_load;
				b_src = pipe_pkg::b_imm_sext8;
			end
			isa_pkg::op_beqz, isa_pkg::op_bnez: branch = 1'b1;
			isa_pkg::op_j: jump = 1'b1;
			isa_pkg::op_halt: halt = 1'b1;
			default: ;
		endcase
	end

	// Register file, write-first on a same-cycle read
	always_ff @(posedge clk) begin
		if (wb_en) begin
			regs[wb_sel] <= wb_data;
		end
	end

	assign rs_val = (wb_en && wb_sel == rs_sel) ? wb_data : regs[rs_sel];
	assign rt_val = (wb_en && wb_sel == rt_sel) ? wb_data : regs[rt_sel];

	assign kill = stall || flush;
	assign halt_seen = halt_q || halt;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			halt_q <= 1'b0;
			ex_rs_sel <= '0;
			ex_rt_sel <= '0;
			ex_wr_sel <= '0;
			ex_reg_wr <= 1'b0;
			ex_mem_rd <= 1'b0;
			ex_mem_wr <= 1'b0;
			ex_branch <= 1'b0;
			ex_jump <= 1'b0;
			ex_halt <= 1'b0;
			ex_opcode <= isa_pkg::op_nop;
		end else begin
			halt_q <= halt_q || (halt && !kill);
			ex_rs_sel <= rs_sel;
			ex_rt_sel <= rt_sel;
			ex_wr_sel <= wr_sel;
			ex_reg_wr <= reg_wr && !kill;
			ex_mem_rd <= mem_rd && !kill;
			ex_mem_wr <= mem_wr && !kill;
			ex_branch <= branch && !kill;
			ex_jump <= jump && !kill;
			ex_halt <= halt && !kill;
			ex_opcode <= kill ? isa_pkg::op_nop : opcode;
		end
	end

	always_ff @(posedge clk) begin
		ex_rs_val <= rs_val;
		ex_rt_val <= rt_val;
		ex_imm <= id_instr[isa_pkg::disp11_w-1:0];
		ex_b_src <= b_src;
		ex_alu_op <= alu_op;
		ex_pc2 <= id_pc2;
	end

endmodule

`default_nettype wire

// File: logic/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
	input  wire                           clk,
	input  wire                           arst_n,
	input  wire  [isa_pkg::word_w-1:0]    ex_rs_val,
	input  wire  [isa_pkg::word_w-1:0]    ex_rt_val,
	input  wire  [isa_pkg::disp11_w-1:0]  ex_imm,
	input  pipe_pkg::b_src_t              ex_b_src,
	input  pipe_pkg::alu_op_t             ex_alu_op,
	input  wire  [isa_pkg::reg_w-1:0]     ex_wr_sel,
	input  wire                           ex_reg_wr,
	input  wire                           ex_mem_rd,
	input  wire                           ex_mem_wr,
	input  wire                           ex_branch,
	input  wire                           ex_jump,
	input  wire                           ex_halt,
	input  wire  [isa_pkg::word_w-1:0]    ex_pc2,
	input  isa_pkg::opcode_t              ex_opcode,
	input  pipe_pkg::fwd_t                fwd_a,
	input  pipe_pkg::fwd_t                fwd_b,
	input  wire  [isa_pkg::word_w-1:0]    wb_data,
	output logic                          redirect,
	output logic [isa_pkg::word_w-1:0]    redirect_pc,
	output logic [isa_pkg::word_w-1:0]    mem_result,
	output logic [isa_pkg::word_w-1:0]    mem_store,
	output logic [isa_pkg::reg_w-1:0]     mem_wr_sel,
	output logic                          mem_reg_wr,
	output logic                          mem_rd,
	output logic                          mem_wr,
	output logic                          mem_halt
);

	logic [isa_pkg::word_w-1:0] op_a;
	logic [isa_pkg::word_w-1:0] rt_fwd;
	logic [isa_pkg::word_w-1:0] op_b;
	logic [isa_pkg::word_w-1:0] alu_out;
	logic [isa_pkg::word_w-1:0] imm5_sext;
	logic [isa_pkg::word_w-1:0] imm5_zext;
	logic [isa_pkg::word_w-1:0] imm8_sext;
	logic [isa_pkg::word_w-1:0] disp_sext;

	function automatic logic [isa_pkg::word_w-1:0] fwd_mux(
		input pipe_pkg::fwd_t sel,
		input logic [isa_pkg::word_w-1:0] rf_val,
		input logic [isa_pkg::word_w-1:0] mem_val,
		input logic [isa_pkg::word_w-1:0] wb_val
	);
		case (sel)
			pipe_pkg::fwd_from_mem: return mem_val;
			pipe_pkg::fwd_from_wb:  return wb_val;
			default:                return rf_val;
		endcase
	endfunction

	assign op_a = fwd_mux(fwd_a, ex_rs_val, mem_result, wb_data);
	assign rt_fwd = fwd_mux(fwd_b, ex_rt_val, mem_result, wb_data);

	assign imm5_sext = {{(isa_pkg::word_w - isa_pkg::imm5_w){ex_imm[isa_pkg::imm5_w-1]}},
		ex_imm[isa_pkg::imm5_w-1:0]};
	assign imm5_zext = {{(isa_pkg::word_w - isa_pkg::imm5_w){1'b0}},
		ex_imm[isa_pkg::imm5_w-1:0]};
	assign imm8_sext = {{(isa_pkg::word_w - isa_pkg::imm8_w){ex_imm[isa_pkg::imm8_w-1]}},
		ex_imm[isa_pkg::imm8_w-1:0]};
	assign disp_sext = {{(isa_pkg::word_w - isa_pkg::disp11_w){ex_imm[isa_pkg::disp11_w-1]}},
		ex_imm};

	always_comb begin
		case (ex_b_src)
			pipe_pkg::b_imm_sext5: op_b = imm5_sext;
			pipe_pkg::b_imm_zext5: op_b = imm5_zext;
			pipe_pkg::b_imm_sext8: op_b = imm8_sext;
			default:               op_b = rt_fwd;
		endcase
	end

	// sub and subi take Rs away from operand b
	always_comb begin
		case (ex_alu_op)
			pipe_pkg::alu_sub:    alu_out = op_b - op_a;
			pipe_pkg::alu_xor:    alu_out = op_a ^ op_b;
			pipe_pkg::alu_andn:   alu_out = op_a & ~op_b;
			pipe_pkg::alu_pass_b: alu_out = op_b;
			pipe_pkg::alu_shift_load: begin
				alu_out = {op_a[isa_pkg::word_w-isa_pkg::imm8_w-1:0],
					op_b[isa_pkg::imm8_w-1:0]};
			end
			default:              alu_out = op_a + op_b;
		endcase
	end

	// Branch polarity comes from the opcode, Rs is tested against zero
	assign redirect = ex_jump ||
		(ex_branch && ((op_a == '0) != (ex_opcode == isa_pkg::op_bnez)));
	assign redirect_pc = ex_pc2 + (ex_jump ? disp_sext : imm8_sext);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mem_wr_sel <= '0;
			mem_reg_wr <= 1'b0;
			mem_rd <= 1'b0;
			mem_wr <= 1'b0;
			mem_halt <= 1'b0;
		end else begin
			mem_wr_sel <= ex_wr_sel;
			mem_reg_wr <= ex_reg_wr;
			mem_rd <= ex_mem_rd;
			mem_wr <= ex_mem_wr;
			mem_halt <= ex_halt;
		end
	end

	always_ff @(posedge clk) begin
		mem_result <= alu_out;
		mem_store <= rt_fwd;
	end

endmodule

`default_nettype wire

// File: logic/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
	input  wire                         clk,
	input  wire                         arst_n,
	input  wire                         stall,
	input  wire                         flush,
	input  wire                         halt_seen,
	input  wire                         redirect,
	input  wire  [isa_pkg::word_w-1:0]  redirect_pc,
	output logic [isa_pkg::word_w-1:0]  imem_addr,
	input  wire  [isa_pkg::word_w-1:0]  imem_data,
	output logic [isa_pkg::word_w-1:0]  id_instr,
	output logic [isa_pkg::word_w-1:0]  id_pc2
);

	logic [isa_pkg::word_w-1:0] pc;
	logic [isa_pkg::word_w-1:0] pc2;

	assign imem_addr = pc;
	assign pc2 = pc + pipe_pkg::pc_step;

	// Redirect wins over stall and halt
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= pipe_pkg::reset_pc;
		end else if (redirect) begin
			pc <= redirect_pc;
		end else if (!stall && !halt_seen) begin
			pc <= pc2;
		end
	end

	// Once halt is seen only bubbles follow it
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			id_instr <= isa_pkg::nop_instr;
		end else if (flush) begin
			id_instr <= isa_pkg::nop_instr;
		end else if (!stall) begin
			id_instr <= halt_seen ? isa_pkg::nop_instr : imem_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			id_pc2 <= pc2;
		end
	end

endmodule

`default_nettype wire

// File: logic/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
	input  wire [isa_pkg::reg_w-1:0]  rs_sel,
	input  wire [isa_pkg::reg_w-1:0]  rt_sel,
	input  wire [isa_pkg::reg_w-1:0]  ex_rs_sel,
	input  wire [isa_pkg::reg_w-1:0]  ex_rt_sel,
	input  wire                       ex_mem_rd,
	input  wire [isa_pkg::reg_w-1:0]  ex_wr_sel,
	input  wire [isa_pkg::reg_w-1:0]  mem_wr_sel,
	input  wire                       mem_reg_wr,
	input  wire [isa_pkg::reg_w-1:0]  wb_sel,
	input  wire                       wb_en,
	input  wire                       redirect,
	output pipe_pkg::fwd_t            fwd_a,
	output pipe_pkg::fwd_t            fwd_b,
	output logic                      stall,
	output logic                      flush
);

	// Youngest producer wins
	function automatic pipe_pkg::fwd_t pick(
		input logic [isa_pkg::reg_w-1:0] src,
		input logic [isa_pkg::reg_w-1:0] m_sel,
		input logic m_wr,
		input logic [isa_pkg::reg_w-1:0] w_sel,
		input logic w_wr
	);
		if (m_wr && m_sel == src) begin
			return pipe_pkg::fwd_from_mem;
		end else if (w_wr && w_sel == src) begin
			return pipe_pkg::fwd_from_wb;
		end
		return pipe_pkg::fwd_regfile;
	endfunction

	assign fwd_a = pick(ex_rs_sel, mem_wr_sel, mem_reg_wr, wb_sel, wb_en);
	assign fwd_b = pick(ex_rt_sel, mem_wr_sel, mem_reg_wr, wb_sel, wb_en);

	// Load data is not ready for the next instruction
	assign stall = ex_mem_rd && (ex_wr_sel == rs_sel || ex_wr_sel == rt_sel);
	assign flush = redirect;

endmodule

`default_nettype wire

// File: logic/isa_pkg.sv
`default_nettype none

package isa_pkg;

	localparam int word_w = 16;
	localparam int reg_n = 8;
	localparam int reg_w = 3;

	// Instruction field positions
	localparam int op_w = 5;
	localparam int op_lsb = 11;
	localparam int rs_lsb = 8;
	localparam int rt_lsb = 5;
	localparam int rd_lsb = 2;
	localparam int funct_lsb = 0;
	localparam int funct_w = 2;

	// Immediate widths, all right aligned in the word
	localparam int imm5_w = 5;
	localparam int imm8_w = 8;
	localparam int disp11_w = 11;

	typedef enum logic [op_w-1:0] {
		op_halt  = 5'b00000,
		op_nop   = 5'b00001,
		op_j     = 5'b00100,
		op_addi  = 5'b01000,
		op_subi  = 5'b01001,
		op_xori  = 5'b01010,
		op_andni = 5'b01011,
		op_beqz  = 5'b01100,
		op_bnez  = 5'b01101,
		op_st    = 5'b10000,
		op_ld    = 5'b10001,
		op_slbi  = 5'b10010,
		op_lbi   = 5'b11000,
		op_rtype = 5'b11011
	} opcode_t;

	typedef enum logic [funct_w-1:0] {
		fn_add  = 2'b00,
		fn_sub  = 2'b01,
		fn_xor  = 2'b10,
		fn_andn = 2'b11
	} funct_t;

	// Bubble word
	localparam logic [word_w-1:0] nop_instr = {op_nop, {op_lsb{1'b0}}};

endpackage

`default_nettype wire

// File: logic/mem_wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage (
	input  wire                         clk,
	input  wire                         arst_n,
	input  wire  [isa_pkg::word_w-1:0]  mem_result,
	input  wire  [isa_pkg::word_w-1:0]  mem_store,
	input  wire  [isa_pkg::reg_w-1:0]   mem_wr_sel,
	input  wire                         mem_reg_wr,
	input  wire                         mem_rd,
	input  wire                         mem_wr,
	input  wire                         mem_halt,
	input  wire  [isa_pkg::word_w-1:0]  dmem_rdata,
	output logic                        dmem_en,
	output logic                        dmem_wr,
	output logic [isa_pkg::word_w-1:0]  dmem_addr,
	output logic [isa_pkg::word_w-1:0]  dmem_wdata,
	output logic [isa_pkg::reg_w-1:0]   wb_sel,
	output logic [isa_pkg::word_w-1:0]  wb_data,
	output logic                        wb_en,
	output logic                        wb_rd,
	output logic                        halted
);

	logic wb_halt;
	logic [isa_pkg::word_w-1:0] wb_load;
	logic [isa_pkg::word_w-1:0] wb_result;

	// Address comes straight from the ALU result
	assign dmem_en = mem_rd || mem_wr;
	assign dmem_wr = mem_wr;
	assign dmem_addr = mem_result;
	assign dmem_wdata = mem_store;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_sel <= '0;
			wb_en <= 1'b0;
			wb_rd <= 1'b0;
			wb_halt <= 1'b0;
			halted <= 1'b0;
		end else begin
			wb_sel <= mem_wr_sel;
			wb_en <= mem_reg_wr;
			wb_rd <= mem_rd;
			wb_halt <= mem_halt;
			// Sticky until reset
			halted <= halted || wb_halt;
		end
	end

	always_ff @(posedge clk) begin
		wb_load <= dmem_rdata;
		wb_result <= mem_result;
	end

	assign wb_data = wb_rd ? wb_load : wb_result;

endmodule

`default_nettype wire

// File: logic/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_xor,
		alu_andn,
		alu_pass_b,
		alu_shift_load
	} alu_op_t;

	// ALU operand b source
	typedef enum logic [1:0] {
		b_rt,
		b_imm_sext5,
		b_imm_zext5,
		b_imm_sext8
	} b_src_t;

	typedef enum logic [1:0] {
		fwd_regfile,
		fwd_from_mem,
		fwd_from_wb
	} fwd_t;

	localparam logic [isa_pkg::word_w-1:0] reset_pc = '0;
	localparam logic [isa_pkg::word_w-1:0] pc_step = 2;

endpackage

`default_nettype wire

// File: logic/proc.sv
`timescale 1ns/1ps
`default_nettype none

module proc (
	input  wire                         clk,
	input  wire                         arst_n,
	output logic [isa_pkg::word_w-1:0]  imem_addr,
	input  wire  [isa_pkg::word_w-1:0]  imem_data,
	output logic                        dmem_en,
	output logic                        dmem_wr,
	output logic [isa_pkg::word_w-1:0]  dmem_addr,
	output logic [isa_pkg::word_w-1:0]  dmem_wdata,
	input  wire  [isa_pkg::word_w-1:0]  dmem_rdata,
	output logic                        halted
);

	// Hazard and redirect
	logic stall;
	logic flush;
	logic halt_seen;
	logic redirect;
	logic [isa_pkg::word_w-1:0] redirect_pc;
	pipe_pkg::fwd_t fwd_a;
	pipe_pkg::fwd_t fwd_b;

	// Fetch to decode
	logic [isa_pkg::word_w-1:0] id_instr;
	logic [isa_pkg::word_w-1:0] id_pc2;
	logic [isa_pkg::reg_w-1:0] rs_sel;
	logic [isa_pkg::reg_w-1:0] rt_sel;

	// Decode to execute
	logic [isa_pkg::reg_w-1:0] ex_rs_sel;
	logic [isa_pkg::reg_w-1:0] ex_rt_sel;
	logic [isa_pkg::word_w-1:0] ex_rs_val;
	logic [isa_pkg::word_w-1:0] ex_rt_val;
	logic [isa_pkg::disp11_w-1:0] ex_imm;
	pipe_pkg::b_src_t ex_b_src;
	pipe_pkg::alu_op_t ex_alu_op;
	logic [isa_pkg::reg_w-1:0] ex_wr_sel;
	logic ex_reg_wr;
	logic ex_mem_rd;
	logic ex_mem_wr;
	logic ex_branch;
	logic ex_jump;
	logic ex_halt;
	logic [isa_pkg::word_w-1:0] ex_pc2;
	isa_pkg::opcode_t ex_opcode;

	// Execute to memory
	logic [isa_pkg::word_w-1:0] mem_result;
	logic [isa_pkg::word_w-1:0] mem_store;
	logic [isa_pkg::reg_w-1:0] mem_wr_sel;
	logic mem_reg_wr;
	logic mem_rd;
	logic mem_wr;
	logic mem_halt;

	// Write-back into the register file
	logic [isa_pkg::reg_w-1:0] wb_sel;
	logic [isa_pkg::word_w-1:0] wb_data;
	logic wb_en;

	fetch_stage fetch_i (.*);

	decode_stage decode_i (.*);

	execute_stage execute_i (.*);

	mem_wb_stage mem_wb_i (
		.*,
		.wb_rd ()
	);

	hazard_unit hazard_i (.*);

endmodule

`default_nettype wire
